//--- Makefile
LOG = sim.log

.PHONY: all build run lint clean

all: run

build:
	verilator --binary --timing --top-module tb_idiv -f list.f --Mdir obj_dir

run: build
	./obj_dir/Vtb_idiv | tee $(LOG)
	grep -q "=== PASS ===" $(LOG)

lint:
	verilator --lint-only -Wall --timing --top-module tb_idiv -f list.f

clean:
	rm -rf obj_dir $(LOG)

//--- idiv_controller.sv
`timescale 1ns/1ps
`default_nettype none

module idiv_controller import idiv_pkg::*; #(
    parameter int width_p = 32
) (
    input  wire       clk_i,
    input  wire       reset_i,
    input  wire       v_i,
    output logic      ready_o,
    input  wire       zero_divisor_i,
    input  wire       signed_div_r_i,
    input  wire       adder_neg_i,
    input  wire       opa_neg_i,
    input  wire       opc_neg_i,
    output logic      opa_sel_o,
    output logic      opa_ld_o,
    output logic      opa_inv_o,
    output logic      opa_clr_l_o,
    output opb_sel_e  opb_sel_o,
    output logic      opb_ld_o,
    output logic      opb_inv_o,
    output logic      opb_clr_l_o,
    output opc_sel_e  opc_sel_o,
    output logic      opc_ld_o,
    output logic      latch_signed_div_o,
    output logic      adder_cin_o,
    output logic      v_o,
    input  wire       yumi_i
);

    localparam int cnt_w_lp = $clog2(width_p + 1);
    localparam logic [cnt_w_lp-1:0] calc_max_lp = cnt_w_lp'(width_p);

    idiv_state_e state_r, state_n;

    logic                q_neg_r;
    logic                r_neg_r;
    logic                neg_ld;
    logic                adder_neg_last_r;
    logic [cnt_w_lp-1:0] calc_cnt_r;
    logic                calc_done;

    assign calc_done = (calc_cnt_r == calc_max_lp);

    always_ff @(posedge clk_i) begin
        if (reset_i) begin
            state_r          <= IDIV_WAIT;
            calc_cnt_r       <= '0;
            q_neg_r          <= 1'b0;
            r_neg_r          <= 1'b0;
            adder_neg_last_r <= 1'b0;
        end else begin
            state_r          <= state_n;
            adder_neg_last_r <= adder_neg_i; // picks add or subtract for the next step.
            if (calc_done) begin
                calc_cnt_r <= '0;
            end else if (state_r == IDIV_CALC) begin
                calc_cnt_r <= calc_cnt_r + 1'b1;
            end
            if (neg_ld) begin
                q_neg_r <= (opa_neg_i ^ opc_neg_i) & signed_div_r_i; // signs differ.
                r_neg_r <= opc_neg_i & signed_div_r_i; // remainder follows the dividend.
            end
        end
    end

    always_comb begin
        opa_sel_o          = 1'b0;
        opa_ld_o           = 1'b0;
        opa_inv_o          = ~adder_neg_last_r;
        opa_clr_l_o        = 1'b1;
        opb_sel_o          = OPB_SHIFT;
        opb_ld_o           = 1'b1;
        opb_inv_o          = 1'b0;
        opb_clr_l_o        = 1'b1;
        opc_sel_o          = OPC_SHIFT;
        opc_ld_o           = 1'b1;
        adder_cin_o        = ~adder_neg_last_r;
        neg_ld             = 1'b0;
        latch_signed_div_o = 1'b0;
        state_n            = IDIV_WAIT;
        case (state_r)
            IDIV_WAIT: begin
                opa_sel_o          = 1'b1; // divisor input.
                opc_sel_o          = OPC_LOAD;
                opa_ld_o           = v_i;
                opc_ld_o           = v_i;
                latch_signed_div_o = v_i;
                state_n            = v_i ? IDIV_NEG0 : IDIV_WAIT;
            end
            IDIV_NEG0: begin
                opa_inv_o   = 1'b1; // adder gives minus a.
                opb_clr_l_o = 1'b0;
                adder_cin_o = 1'b1;
                opb_sel_o   = OPB_ZERO_FILL; // b takes the dividend.
                opc_ld_o    = 1'b0;
                opa_ld_o    = opa_neg_i & signed_div_r_i;
                neg_ld      = 1'b1;
                state_n     = (opc_neg_i & signed_div_r_i) ? IDIV_NEG1 : IDIV_SHIFT;
            end
            IDIV_NEG1: begin
                opa_clr_l_o = 1'b0;
                opb_inv_o   = 1'b1;
                adder_cin_o = 1'b1;
                opb_ld_o    = 1'b0;
                opc_sel_o   = OPC_ADDER;
                state_n     = IDIV_SHIFT;
            end
            IDIV_SHIFT: begin
                opa_clr_l_o = 1'b0; // zero sum, so b starts from the dividend top bit.
                opb_clr_l_o = 1'b0;
                adder_cin_o = 1'b0;
                state_n     = IDIV_CALC;
            end
            IDIV_CALC: begin
                opb_sel_o = calc_done ? OPB_ADDER : OPB_SHIFT;
                if (calc_done) begin
                    state_n = adder_neg_i ? IDIV_REPAIR : IDIV_REMAIN;
                end else begin
                    state_n = IDIV_CALC;
                end
            end
            IDIV_REPAIR: begin
                opa_inv_o   = 1'b0; // add the divisor back.
                adder_cin_o = 1'b0;
                opb_sel_o   = OPB_ADDER;
                opc_ld_o    = 1'b0;
                state_n     = IDIV_REMAIN;
            end
            IDIV_REMAIN: begin
                opa_ld_o    = 1'b1; // a takes the signed remainder.
                opa_clr_l_o = 1'b0;
                opb_inv_o   = r_neg_r;
                adder_cin_o = r_neg_r;
                opb_sel_o   = OPB_ZERO_FILL;
                opc_ld_o    = 1'b0;
                state_n     = (zero_divisor_i | ~q_neg_r) ? IDIV_DONE : IDIV_QUOT;
            end
            IDIV_QUOT: begin
                opa_clr_l_o = 1'b0;
                opb_inv_o   = 1'b1;
                adder_cin_o = 1'b1;
                opb_ld_o    = 1'b0;
                opc_sel_o   = OPC_ADDER;
                state_n     = IDIV_DONE;
            end
            IDIV_DONE: begin
                opb_ld_o = 1'b0; // hold results while the consumer waits.
                opc_ld_o = 1'b0;
                state_n  = yumi_i ? IDIV_WAIT : IDIV_DONE;
            end
            default: begin
                state_n = IDIV_WAIT;
            end
        endcase
    end

    assign ready_o = (state_r == IDIV_WAIT);
    assign v_o     = (state_r == IDIV_DONE);

endmodule

`default_nettype wire

//--- idiv_datapath.sv
`timescale 1ns/1ps
`default_nettype none

module idiv_datapath import idiv_pkg::*; #(
    parameter int width_p = 32
) (
    input  wire                clk_i,
    input  wire                reset_i,
    input  wire  [width_p-1:0] dividend_i,
    input  wire  [width_p-1:0] divisor_i,
    input  wire                signed_div_i,
    input  wire                opa_sel_i,
    input  wire                opa_ld_i,
    input  wire                opa_inv_i,
    input  wire                opa_clr_l_i,
    input  opb_sel_e           opb_sel_i,
    input  wire                opb_ld_i,
    input  wire                opb_inv_i,
    input  wire                opb_clr_l_i,
    input  opc_sel_e           opc_sel_i,
    input  wire                opc_ld_i,
    input  wire                latch_signed_div_i,
    input  wire                adder_cin_i,
    output logic               zero_divisor_o,
    output logic               signed_div_r_o,
    output logic               adder_neg_o,
    output logic               opa_neg_o,
    output logic               opc_neg_o,
    output logic [width_p-1:0] quotient_o,
    output logic [width_p-1:0] remainder_o
);

    logic [width_p:0] opa_r;
    logic [width_p:0] opb_r;
    logic [width_p:0] opc_r;
    logic [width_p:0] opa_mux;
    logic [width_p:0] opb_mux;
    logic [width_p:0] opc_mux;
    logic [width_p:0] add_in0;
    logic [width_p:0] add_in1;
    logic [width_p:0] add_out;
    logic             divisor_msb;
    logic             dividend_msb;

    // operands are sign extended by one bit for a signed division.
    assign divisor_msb  = signed_div_i & divisor_i[width_p-1];
    assign dividend_msb = signed_div_i & dividend_i[width_p-1];

    assign add_in0 = (opa_r ^ {(width_p+1){opa_inv_i}}) & {(width_p+1){opa_clr_l_i}};
    assign add_in1 = (opb_r ^ {(width_p+1){opb_inv_i}}) & {(width_p+1){opb_clr_l_i}};
    assign add_out = add_in0 + add_in1 + {{width_p{1'b0}}, adder_cin_i};

    assign opa_mux = opa_sel_i ? {divisor_msb, divisor_i} : add_out;

    always_comb begin
        case (opb_sel_i)
            OPB_SHIFT:     opb_mux = {add_out[width_p-1:0], opc_r[width_p]};
            OPB_ADDER:     opb_mux = add_out;
            OPB_ZERO_FILL: opb_mux = opc_r;
            default:       opb_mux = opb_r;
        endcase
    end

    always_comb begin
        case (opc_sel_i)
            OPC_SHIFT: opc_mux = {opc_r[width_p-1:0], ~add_out[width_p]}; // new quotient bit.
            OPC_ADDER: opc_mux = add_out;
            OPC_LOAD:  opc_mux = {dividend_msb, dividend_i};
            default:   opc_mux = opc_r;
        endcase
    end

    always_ff @(posedge clk_i) begin
        if (opa_ld_i) begin
            opa_r <= opa_mux;
        end
        if (opb_ld_i) begin
            opb_r <= opb_mux;
        end
        if (opc_ld_i) begin
            opc_r <= opc_mux;
        end
    end

    always_ff @(posedge clk_i) begin
        if (reset_i) begin
            signed_div_r_o <= 1'b0;
        end else if (latch_signed_div_i) begin
            signed_div_r_o <= signed_div_i;
        end
    end

    assign zero_divisor_o = ~|opa_r;
    assign adder_neg_o    = add_out[width_p];
    assign opa_neg_o      = opa_r[width_p];
    assign opc_neg_o      = opc_r[width_p];

    // a ends up with the remainder and c with the quotient.
    assign quotient_o  = opc_r[width_p-1:0];
    assign remainder_o = opa_r[width_p-1:0];

endmodule

`default_nettype wire

//--- idiv_iterative.sv
`timescale 1ns/1ps
`default_nettype none

module idiv_iterative import idiv_pkg::*; #(
    parameter int width_p = 32
) (
    input  wire                clk_i,
    input  wire                reset_i,
    input  wire                v_i,
    output logic               ready_o,
    input  wire  [width_p-1:0] dividend_i,
    input  wire  [width_p-1:0] divisor_i,
    input  wire                signed_div_i,
    output logic               v_o,
    output logic [width_p-1:0] quotient_o,
    output logic [width_p-1:0] remainder_o,
    input  wire                yumi_i
);

    logic     opa_sel;
    logic     opa_ld;
    logic     opa_inv;
    logic     opa_clr_l;
    opb_sel_e opb_sel;
    logic     opb_ld;
    logic     opb_inv;
    logic     opb_clr_l;
    opc_sel_e opc_sel;
    logic     opc_ld;
    logic     latch_signed_div;
    logic     adder_cin;
    logic     zero_divisor;
    logic     signed_div_r;
    logic     adder_neg;
    logic     opa_neg;
    logic     opc_neg;

    idiv_controller #(.width_p(width_p)) controller (
        .clk_i(clk_i),                   .reset_i(reset_i),
        .v_i(v_i),                       .ready_o(ready_o),
        .zero_divisor_i(zero_divisor),   .signed_div_r_i(signed_div_r),
        .adder_neg_i(adder_neg),         .opa_neg_i(opa_neg),
        .opc_neg_i(opc_neg),             .opa_sel_o(opa_sel),
        .opa_ld_o(opa_ld),               .opa_inv_o(opa_inv),
        .opa_clr_l_o(opa_clr_l),         .opb_sel_o(opb_sel),
        .opb_ld_o(opb_ld),               .opb_inv_o(opb_inv),
        .opb_clr_l_o(opb_clr_l),         .opc_sel_o(opc_sel),
        .opc_ld_o(opc_ld),               .latch_signed_div_o(latch_signed_div),
        .adder_cin_o(adder_cin),         .v_o(v_o),
        .yumi_i(yumi_i)
    );

    idiv_datapath #(.width_p(width_p)) datapath (
        .clk_i(clk_i),                   .reset_i(reset_i),
        .dividend_i(dividend_i),         .divisor_i(divisor_i),
        .signed_div_i(signed_div_i),     .opa_sel_i(opa_sel),
        .opa_ld_i(opa_ld),               .opa_inv_i(opa_inv),
        .opa_clr_l_i(opa_clr_l),         .opb_sel_i(opb_sel),
        .opb_ld_i(opb_ld),               .opb_inv_i(opb_inv),
        .opb_clr_l_i(opb_clr_l),         .opc_sel_i(opc_sel),
        .opc_ld_i(opc_ld),               .latch_signed_div_i(latch_signed_div),
        .adder_cin_i(adder_cin),         .zero_divisor_o(zero_divisor),
        .signed_div_r_o(signed_div_r),   .adder_neg_o(adder_neg),
        .opa_neg_o(opa_neg),             .opc_neg_o(opc_neg),
        .quotient_o(quotient_o),         .remainder_o(remainder_o)
    );

endmodule

`default_nettype wire

//--- idiv_pkg.sv
`default_nettype none

package idiv_pkg;

    // controller states for one division.
    typedef enum logic [5:0] {
        IDIV_WAIT   = 6'd0,
        IDIV_NEG0   = 6'd1, // negate the divisor if needed.
        IDIV_NEG1   = 6'd2, // negate the dividend.
        IDIV_SHIFT  = 6'd3,
        IDIV_CALC   = 6'd4,
        IDIV_REPAIR = 6'd5,
        IDIV_REMAIN = 6'd6,
        IDIV_QUOT   = 6'd7,
        IDIV_DONE   = 6'd8
    } idiv_state_e;

    // one-hot source select for the partial remainder register.
    typedef enum logic [2:0] {
        OPB_SHIFT     = 3'b001, // adder result shifted left with the next dividend bit.
        OPB_ADDER     = 3'b010,
        OPB_ZERO_FILL = 3'b100  // takes register c, the dividend or the quotient.
    } opb_sel_e;

    // one-hot source select for the dividend and quotient register.
    typedef enum logic [2:0] {
        OPC_SHIFT = 3'b001, // shifts in the quotient bit.
        OPC_ADDER = 3'b010,
        OPC_LOAD  = 3'b100
    } opc_sel_e;

endpackage

`default_nettype wire

//--- list.f
idiv_pkg.sv
idiv_controller.sv
idiv_datapath.sv
idiv_iterative.sv
tb_clock_gen.sv
tb_idiv_checker.sv
tb_idiv.sv

//--- tb_clock_gen.sv
`timescale 1ns/1ps
`default_nettype none

module tb_clock_gen #(
    parameter int half_period_p  = 5,
    parameter int reset_cycles_p = 10
) (
    output logic clk_o,
    output logic reset_o
);

    initial begin
        clk_o = 1'b0;
        forever #(half_period_p) clk_o = ~clk_o;
    end

    initial begin
        reset_o = 1'b1;
        repeat (reset_cycles_p) @(posedge clk_o);
        @(negedge clk_o);
        reset_o <= 1'b0; // released half a cycle away from the sampling edge.
    end

endmodule

`default_nettype wire

//--- tb_idiv.sv
`timescale 1ns/1ps
`default_nettype none

module tb_idiv;

    localparam int width_lp    = 32;
    localparam int directed_lp = 18;
    localparam int random_lp   = 20;
    localparam int rows_lp     = directed_lp + random_lp;
    localparam int limit_lp    = rows_lp * (width_lp + 12) + 100;

    logic        clk;
    logic        reset;
    logic        v;
    logic        ready;
    logic [31:0] dividend;
    logic [31:0] divisor;
    logic        signed_div;
    logic        res_v;
    logic [31:0] quotient;
    logic [31:0] remainder;
    logic        yumi;
    logic [31:0] exp_quot;
    logic [31:0] exp_rem;
    logic [31:0] tab_dividend [rows_lp];
    logic [31:0] tab_divisor [rows_lp];
    logic        tab_signed [rows_lp];
    logic [31:0] tab_quot [rows_lp];
    logic [31:0] tab_rem [rows_lp];
    logic [31:0] stim_rng;
    logic [31:0] yumi_rng;
    int          row_cnt;
    int          cycle_cnt;
    int          pass_count;
    int          fail_count;
    int          done_count;

    tb_clock_gen clock_gen (.clk_o(clk), .reset_o(reset));

    idiv_iterative #(.width_p(width_lp)) uut (
        .clk_i(clk), .reset_i(reset), .v_i(v), .ready_o(ready),
        .dividend_i(dividend), .divisor_i(divisor), .signed_div_i(signed_div),
        .v_o(res_v), .quotient_o(quotient), .remainder_o(remainder), .yumi_i(yumi)
    );

    tb_idiv_checker #(.width_p(width_lp)) result_check (
        .clk_i(clk), .reset_i(reset), .req_v_i(v), .req_ready_i(ready),
        .exp_quot_i(exp_quot), .exp_rem_i(exp_rem), .res_v_i(res_v), .res_yumi_i(yumi),
        .quotient_i(quotient), .remainder_i(remainder), .pass_count_o(pass_count),
        .fail_count_o(fail_count), .done_count_o(done_count)
    );

    function automatic logic [31:0] xorshift32(input logic [31:0] x);
        logic [31:0] y;
        y = x ^ (x << 13);
        y = y ^ (y >> 17);
        y = y ^ (y << 5);
        return y;
    endfunction

    // quotient truncates toward zero and the remainder takes the dividend's sign.
    function automatic logic [63:0] reference_div(input logic [31:0] a, input logic [31:0] b,
                                                  input logic s);
        logic [31:0] mag_a;
        logic [31:0] mag_b;
        logic [31:0] q;
        logic [31:0] r;
        mag_a = (s && a[31]) ? -a : a;
        mag_b = (s && b[31]) ? -b : b;
        if (b == 32'd0) begin
            return {32'hFFFF_FFFF, a};
        end
        if (s && a == 32'h8000_0000 && b == 32'hFFFF_FFFF) begin
            return {a, 32'd0};
        end
        q = mag_a / mag_b;
        r = mag_a % mag_b;
        if (s && (a[31] ^ b[31])) begin
            q = -q;
        end
        if (s && a[31]) begin
            r = -r;
        end
        return {q, r};
    endfunction

    task automatic add_row(input logic [31:0] a, input logic [31:0] b, input logic s,
                           input logic [31:0] q, input logic [31:0] r);
        tab_dividend[row_cnt] = a;
        tab_divisor[row_cnt]  = b;
        tab_signed[row_cnt]   = s;
        tab_quot[row_cnt]     = q;
        tab_rem[row_cnt]      = r;
        row_cnt++;
    endtask

    initial begin : stimulus
        logic [63:0] expect_pair;
        logic [31:0] a;
        logic [31:0] b;
        v          = 1'b0;
        dividend   = 32'd0;
        divisor    = 32'd0;
        signed_div = 1'b0;
        exp_quot   = 32'd0;
        exp_rem    = 32'd0;
        stim_rng   = 32'd9;
        row_cnt    = 0;
        add_row(32'd100, 32'd7, 1'b0, 32'd14, 32'd2);
        add_row(32'd7, 32'd100, 1'b0, 32'd0, 32'd7);
        add_row(32'hFFFF_FFFF, 32'd1, 1'b0, 32'hFFFF_FFFF, 32'd0);
        add_row(32'hFFFF_FFFF, 32'hFFFF_FFFF, 1'b0, 32'd1, 32'd0);
        add_row(32'h8000_0000, 32'd3, 1'b0, 32'h2AAA_AAAA, 32'd2);
        add_row(32'd12345, 32'd12345, 1'b0, 32'd1, 32'd0);
        add_row(32'd7, 32'd2, 1'b1, 32'd3, 32'd1);
        add_row(32'hFFFF_FFF9, 32'd2, 1'b1, 32'hFFFF_FFFD, 32'hFFFF_FFFF);
        add_row(32'd7, 32'hFFFF_FFFE, 1'b1, 32'hFFFF_FFFD, 32'd1);
        add_row(32'hFFFF_FFF9, 32'hFFFF_FFFE, 1'b1, 32'd3, 32'hFFFF_FFFF);
        add_row(32'hFFFF_FFF9, 32'd2, 1'b0, 32'h7FFF_FFFC, 32'd1);
        add_row(32'd1234, 32'd0, 1'b0, 32'hFFFF_FFFF, 32'd1234);
        add_row(32'hFFFF_FF00, 32'd0, 1'b1, 32'hFFFF_FFFF, 32'hFFFF_FF00);
        add_row(32'h8000_0000, 32'hFFFF_FFFF, 1'b1, 32'h8000_0000, 32'd0);
        add_row(32'h8000_0000, 32'd2, 1'b1, 32'hC000_0000, 32'd0);
        add_row(32'd0, 32'hFFFF_FFFB, 1'b1, 32'd0, 32'd0);
        add_row(32'hFFFF_FFFF, 32'd1, 1'b1, 32'hFFFF_FFFF, 32'd0);
        add_row(32'h7FFF_FFFF, 32'h8000_0000, 1'b1, 32'd0, 32'h7FFF_FFFF);
        for (int i = 0; i < random_lp; i++) begin
            stim_rng    = xorshift32(stim_rng);
            a           = stim_rng;
            stim_rng    = xorshift32(stim_rng);
            b           = stim_rng;
            stim_rng    = xorshift32(stim_rng);
            b           = b >> stim_rng[4:0]; // spread divisor sizes.
            expect_pair = reference_div(a, b, stim_rng[5]);
            add_row(a, b, stim_rng[5], expect_pair[63:32], expect_pair[31:0]);
        end
        @(negedge clk);
        while (reset) @(negedge clk);
        for (int i = 0; i < rows_lp; i++) begin
            v          = 1'b1;
            dividend   = tab_dividend[i];
            divisor    = tab_divisor[i];
            signed_div = tab_signed[i];
            exp_quot   = tab_quot[i];
            exp_rem    = tab_rem[i];
            while (!ready) @(negedge clk);
            @(negedge clk); // the transfer took place on the edge in between.
        end
        v = 1'b0;
        while (done_count < rows_lp) @(negedge clk);
        $display("%0d tests passed, %0d failed", pass_count, fail_count);
        if (fail_count == 0 && pass_count == rows_lp) begin
            $display("=== PASS ===");
        end else begin
            $display("=== FAIL ===");
        end
        $finish;
    end

    initial begin : consume
        int delay;
        yumi     = 1'b0;
        yumi_rng = 32'd9;
        forever begin
            @(negedge clk);
            if (res_v) begin
                yumi_rng = xorshift32(yumi_rng);
                delay    = int'(yumi_rng[1:0]);
                repeat (delay) @(negedge clk);
                yumi = 1'b1;
                @(negedge clk);
                yumi = 1'b0;
            end
        end
    end

    initial begin : watchdog
        cycle_cnt = 0;
        while (cycle_cnt < limit_lp) begin
            @(posedge clk);
            cycle_cnt++;
        end
        $display("timeout: the run did not finish within %0d cycles", limit_lp);
        $display("=== FAIL ===");
        $finish;
    end

endmodule

`default_nettype wire

//--- tb_idiv_checker.sv
`timescale 1ns/1ps
`default_nettype none

module tb_idiv_checker #(
    parameter int width_p = 32
) (
    input  wire               clk_i,
    input  wire               reset_i,
    input  wire               req_v_i,
    input  wire               req_ready_i,
    input  wire [width_p-1:0] exp_quot_i,
    input  wire [width_p-1:0] exp_rem_i,
    input  wire               res_v_i,
    input  wire               res_yumi_i,
    input  wire [width_p-1:0] quotient_i,
    input  wire [width_p-1:0] remainder_i,
    output int                pass_count_o,
    output int                fail_count_o,
    output int                done_count_o
);

    logic [2*width_p-1:0] pending_q [$]; // expected pairs in order of acceptance.
    logic [2*width_p-1:0] expect_pair;
    logic                 held_v_r = 1'b0;
    logic [width_p-1:0]   held_quot_r;
    logic [width_p-1:0]   held_rem_r;
    logic                 reset_d_r = 1'b0;
    int                   pass_cnt = 0;
    int                   fail_cnt = 0;
    int                   done_cnt = 0;

    assign pass_count_o = pass_cnt;
    assign fail_count_o = fail_cnt;
    assign done_count_o = done_cnt;

    always @(posedge clk_i) begin
        if (reset_d_r && !reset_i && (req_ready_i !== 1'b1 || res_v_i !== 1'b0)) begin
            $display("error at %0t: ready is not high or a result is valid after reset", $time);
            fail_cnt++;
        end
        if (!reset_i) begin
            if (req_v_i && req_ready_i) begin
                pending_q.push_back({exp_quot_i, exp_rem_i});
            end
            if (res_v_i && req_ready_i) begin
                $display("error at %0t: a new operand could be taken while a result waits", $time);
                fail_cnt++;
            end
            if (res_v_i && held_v_r &&
                (quotient_i !== held_quot_r || remainder_i !== held_rem_r)) begin
                $display("MISMATCH at %0t: result moved while waiting, q %h to %h, r %h to %h",
                         $time, held_quot_r, quotient_i, held_rem_r, remainder_i);
                fail_cnt++;
            end
            if (res_v_i && res_yumi_i) begin
                if (pending_q.size() == 0) begin
                    $display("error at %0t: a result arrived with no expected value pending",
                             $time);
                    fail_cnt++;
                end else begin
                    expect_pair = pending_q.pop_front();
                    if (quotient_i !== expect_pair[2*width_p-1:width_p] ||
                        remainder_i !== expect_pair[width_p-1:0]) begin
                        $display("MISMATCH at %0t: test %0d q %h expected %h, r %h expected %h",
                                 $time, done_cnt, quotient_i, expect_pair[2*width_p-1:width_p],
                                 remainder_i, expect_pair[width_p-1:0]);
                        fail_cnt++;
                    end else begin
                        $display("test %0d passed: quotient %h remainder %h",
                                 done_cnt, quotient_i, remainder_i);
                        pass_cnt++;
                    end
                    done_cnt++;
                end
            end
        end
        held_v_r    = res_v_i && !res_yumi_i && !reset_i; // result still owed next cycle.
        held_quot_r = quotient_i;
        held_rem_r  = remainder_i;
        reset_d_r   = reset_i;
    end

endmodule

`default_nettype wire
